//--- verilog/tcdm_macros.svh
// Width and size macros for the TCDM subsystem, included by every file that sizes a bus
`ifndef TCDM_MACROS_SVH
`define TCDM_MACROS_SVH

// Channels per side, also the number of banks
`define TCDM_NB_CHAN 2

// Word address inside one bank (64 words)
`define TCDM_ADDR_W 6

// Data word and its byte enables
`define TCDM_DATA_W 32
`define TCDM_BE_W (`TCDM_DATA_W / 8)

// Low-side stall counter and limit
`define TCDM_STALL_W 8

`endif

//--- verilog/tcdm_pkg.sv
// Shared bus field types for the TCDM subsystem, imported by RTL and testbench
`include "tcdm_macros.svh"

package tcdm_pkg;

  // ------------------------------------------------------------
  // Bus fields
  // ------------------------------------------------------------

  typedef logic [`TCDM_ADDR_W-1:0] tcdm_addr_t;  // Word address in a bank
  typedef logic [`TCDM_DATA_W-1:0] tcdm_data_t;  // Write and read data
  typedef logic [`TCDM_BE_W-1:0]   tcdm_be_t;    // One bit per byte lane

  // ------------------------------------------------------------
  // Arbitration
  // ------------------------------------------------------------

  // Consecutive low-side stalls, same width as the programmed limit
  typedef logic [`TCDM_STALL_W-1:0] stall_cnt_t;

endpackage

//--- verilog/tcdm_bus_if.sv
// One TCDM request/response channel, shared by initiators, memory targets and the response monitor
interface tcdm_bus_if;
  import tcdm_pkg::*;

  // Request phase
  logic       req;     // Held until accepted
  logic       gnt;     // Combinational accept
  tcdm_addr_t add;
  logic       wen;     // 1 = read, 0 = write
  tcdm_be_t   be;
  tcdm_data_t data;

  // Response phase, one cycle after accept
  tcdm_data_t r_data;  // Meaningless after a write
  logic       r_valid;

  // Issues requests, waits for gnt
  modport initiator (
    output req, add, wen, be, data,
    input  gnt, r_data, r_valid
  );

  // Memory side; r_valid comes from the steering block instead
  modport target (
    input  req, add, wen, be, data,
    output gnt, r_data
  );

  // Watches accepts and raises r_valid
  modport monitor (
    input  req, gnt,
    output r_valid
  );

endinterface

//--- verilog/prio_arbiter.sv
// Starvation-free two-side arbiter placed between the high/low initiator channels and the banks
`include "tcdm_macros.svh"

module prio_arbiter (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                invert_prio_i,        // Swap high and low sides
  input  tcdm_pkg::stall_cnt_t low_prio_max_stall_i, // 0 disables the limit

  tcdm_bus_if.target          hi_bus   [`TCDM_NB_CHAN],
  tcdm_bus_if.target          lo_bus   [`TCDM_NB_CHAN],
  tcdm_bus_if.initiator       bank_bus [`TCDM_NB_CHAN]
);
  import tcdm_pkg::*;

  logic [`TCDM_NB_CHAN-1:0] hs_req_map;  // Requests of the side with priority
  logic [`TCDM_NB_CHAN-1:0] ls_req_map;  // Requests of the other side
  logic [`TCDM_NB_CHAN-1:0] hi_pass;     // 1 routes the physical high side
  logic                     swap;
  logic                     conflict;    // Both sides on one channel
  logic                     hs_req_eff;  // Priority side request after stall rule
  stall_cnt_t               stall_q;

  assign swap = invert_prio_i;

  // ------------------------------------------------------------
  // Request mapping
  // ------------------------------------------------------------

  for (genvar ii = 0; ii < `TCDM_NB_CHAN; ii++)
  begin : g_req_map
    always_comb
    begin
      if (swap)
      begin
        hs_req_map[ii] = lo_bus[ii].req;  // Low side now has priority
        ls_req_map[ii] = hi_bus[ii].req;
      end
      else
      begin
        hs_req_map[ii] = hi_bus[ii].req;
        ls_req_map[ii] = lo_bus[ii].req;
      end
    end
  end

  assign conflict = |(hs_req_map & ls_req_map);

  // ------------------------------------------------------------
  // Stall rule
  // ------------------------------------------------------------

  always_comb
  begin
    hs_req_eff = |hs_req_map;
    // Limit reached, let the low side through once
    if ((low_prio_max_stall_i != '0) && (stall_q >= low_prio_max_stall_i))
      hs_req_eff = 1'b0;
  end

  // Counts cycles where the priority side keeps beating a waiting low side
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      stall_q <= '0;
    else if (clear_i)
      stall_q <= '0;
    else if (conflict && hs_req_eff)
      stall_q <= stall_q + stall_cnt_t'(1);
    else
      stall_q <= '0;                      // Low side got through, or no contention
  end

  // ------------------------------------------------------------
  // Side select and routing
  // ------------------------------------------------------------

  for (genvar ii = 0; ii < `TCDM_NB_CHAN; ii++)
  begin : g_route
    // XOR maps the priority-side decision back to physical sides
    assign hi_pass[ii] = (hs_req_eff & hs_req_map[ii]) ^ swap;

    always_comb
    begin
      hi_bus[ii].gnt = 1'b0;
      lo_bus[ii].gnt = 1'b0;
      if (hi_pass[ii])
      begin
        bank_bus[ii].req  = hi_bus[ii].req;
        bank_bus[ii].add  = hi_bus[ii].add;
        bank_bus[ii].wen  = hi_bus[ii].wen;
        bank_bus[ii].be   = hi_bus[ii].be;
        bank_bus[ii].data = hi_bus[ii].data;
        hi_bus[ii].gnt    = bank_bus[ii].gnt;
      end
      else
      begin
        bank_bus[ii].req  = lo_bus[ii].req;
        bank_bus[ii].add  = lo_bus[ii].add;
        bank_bus[ii].wen  = lo_bus[ii].wen;
        bank_bus[ii].be   = lo_bus[ii].be;
        bank_bus[ii].data = lo_bus[ii].data;
        lo_bus[ii].gnt    = bank_bus[ii].gnt;
      end
      // Read data goes to both, r_valid tells who owns it
      hi_bus[ii].r_data = bank_bus[ii].r_data;
      lo_bus[ii].r_data = bank_bus[ii].r_data;
    end
  end

endmodule

//--- verilog/tcdm_bank.sv
// Single-ported word memory bank with byte-enable writes and registered read data
`include "tcdm_macros.svh"

module tcdm_bank (
  input  logic       clk_i,
  input  logic       rst_ni,
  tcdm_bus_if.target bus
);
  import tcdm_pkg::*;

  localparam int unsigned NbWords = 2 ** `TCDM_ADDR_W;

  tcdm_data_t mem_q [NbWords];  // Word storage
  tcdm_data_t r_data_q;
  logic       wr_en;
  logic       rd_en;

  // Never stalls, every request accepted at once
  assign bus.gnt = bus.req;

  assign wr_en = bus.req & ~bus.wen;
  assign rd_en = bus.req &  bus.wen;

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------

  // Only enabled byte lanes change
  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      for (int b = 0; b < `TCDM_BE_W; b++)
      begin
        if (bus.be[b])
          mem_q[bus.add][8*b +: 8] <= bus.data[8*b +: 8];
      end
    end
  end

  // ------------------------------------------------------------
  // Read port
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      r_data_q <= '0;
    else if (rd_en)
      r_data_q <= mem_q[bus.add];  // Visible one cycle after accept
  end

  assign bus.r_data = r_data_q;  // Holds last read otherwise

endmodule

//--- verilog/resp_steer.sv
// Per-channel response steering that raises r_valid on the side a bank accepted one cycle before
`include "tcdm_macros.svh"

module resp_steer (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  tcdm_bus_if.monitor hi_bus [`TCDM_NB_CHAN],
  tcdm_bus_if.monitor lo_bus [`TCDM_NB_CHAN]
);

  logic [`TCDM_NB_CHAN-1:0] hi_acc;    // High side accepted this cycle
  logic [`TCDM_NB_CHAN-1:0] lo_acc;
  logic [`TCDM_NB_CHAN-1:0] hi_acc_q;  // Accepted last cycle
  logic [`TCDM_NB_CHAN-1:0] lo_acc_q;

  // ------------------------------------------------------------
  // Accept detect
  // ------------------------------------------------------------

  for (genvar n = 0; n < `TCDM_NB_CHAN; n++)
  begin : g_acc
    assign hi_acc[n] = hi_bus[n].req & hi_bus[n].gnt;
    assign lo_acc[n] = lo_bus[n].req & lo_bus[n].gnt;  // Exclusive with hi_acc

    // One-cycle pulse, back-to-back when accepts are
    assign hi_bus[n].r_valid = hi_acc_q[n];
    assign lo_bus[n].r_valid = lo_acc_q[n];
  end

  // ------------------------------------------------------------
  // Response delay
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      hi_acc_q <= '0;
      lo_acc_q <= '0;
    end
    else if (clear_i)
    begin
      hi_acc_q <= '0;  // Drops responses in flight
      lo_acc_q <= '0;
    end
    else
    begin
      hi_acc_q <= hi_acc;
      lo_acc_q <= lo_acc;
    end
  end

endmodule

//--- verilog/tcdm_subsystem_top.sv
// Top level of the shared scratchpad, two initiator sides arbitrated onto one bank per channel
`include "tcdm_macros.svh"

module tcdm_subsystem_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     invert_prio_i,
  input  tcdm_pkg::stall_cnt_t     low_prio_max_stall_i,

  // High-priority side
  input  logic [`TCDM_NB_CHAN-1:0] hi_req_i,
  output logic [`TCDM_NB_CHAN-1:0] hi_gnt_o,
  input  tcdm_pkg::tcdm_addr_t     hi_add_i    [`TCDM_NB_CHAN],
  input  logic [`TCDM_NB_CHAN-1:0] hi_wen_i,
  input  tcdm_pkg::tcdm_be_t       hi_be_i     [`TCDM_NB_CHAN],
  input  tcdm_pkg::tcdm_data_t     hi_data_i   [`TCDM_NB_CHAN],
  output tcdm_pkg::tcdm_data_t     hi_r_data_o [`TCDM_NB_CHAN],
  output logic [`TCDM_NB_CHAN-1:0] hi_r_valid_o,

  // Low-priority side
  input  logic [`TCDM_NB_CHAN-1:0] lo_req_i,
  output logic [`TCDM_NB_CHAN-1:0] lo_gnt_o,
  input  tcdm_pkg::tcdm_addr_t     lo_add_i    [`TCDM_NB_CHAN],
  input  logic [`TCDM_NB_CHAN-1:0] lo_wen_i,
  input  tcdm_pkg::tcdm_be_t       lo_be_i     [`TCDM_NB_CHAN],
  input  tcdm_pkg::tcdm_data_t     lo_data_i   [`TCDM_NB_CHAN],
  output tcdm_pkg::tcdm_data_t     lo_r_data_o [`TCDM_NB_CHAN],
  output logic [`TCDM_NB_CHAN-1:0] lo_r_valid_o
);

  tcdm_bus_if hi_bus   [`TCDM_NB_CHAN] ();
  tcdm_bus_if lo_bus   [`TCDM_NB_CHAN] ();
  tcdm_bus_if bank_bus [`TCDM_NB_CHAN] ();  // Arbiter to bank

  // ------------------------------------------------------------
  // Port mapping
  // ------------------------------------------------------------

  for (genvar n = 0; n < `TCDM_NB_CHAN; n++)
  begin : g_ports
    assign hi_bus[n].req  = hi_req_i[n];
    assign hi_bus[n].add  = hi_add_i[n];
    assign hi_bus[n].wen  = hi_wen_i[n];
    assign hi_bus[n].be   = hi_be_i[n];
    assign hi_bus[n].data = hi_data_i[n];
    assign hi_gnt_o[n]     = hi_bus[n].gnt;
    assign hi_r_data_o[n]  = hi_bus[n].r_data;
    assign hi_r_valid_o[n] = hi_bus[n].r_valid;

    assign lo_bus[n].req  = lo_req_i[n];
    assign lo_bus[n].add  = lo_add_i[n];
    assign lo_bus[n].wen  = lo_wen_i[n];
    assign lo_bus[n].be   = lo_be_i[n];
    assign lo_bus[n].data = lo_data_i[n];
    assign lo_gnt_o[n]     = lo_bus[n].gnt;
    assign lo_r_data_o[n]  = lo_bus[n].r_data;
    assign lo_r_valid_o[n] = lo_bus[n].r_valid;

    // One bank per channel, no interleaving
    tcdm_bank u_bank (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .bus    (bank_bus[n])
    );
  end

  // ------------------------------------------------------------
  // Arbitration and response steering
  // ------------------------------------------------------------

  prio_arbiter u_arbiter (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .clear_i              (clear_i),
    .invert_prio_i        (invert_prio_i),
    .low_prio_max_stall_i (low_prio_max_stall_i),
    .hi_bus               (hi_bus),
    .lo_bus               (lo_bus),
    .bank_bus             (bank_bus)
  );

  resp_steer u_resp_steer (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .hi_bus  (hi_bus),
    .lo_bus  (lo_bus)
  );

endmodule

//--- testbench/tb_tcdm_subsystem.sv
// Directed testbench for the TCDM subsystem, compiled from project.f with tb_tcdm_subsystem as top
`include "tcdm_macros.svh"

module tb_tcdm_subsystem;
  import tcdm_pkg::*;

  localparam int unsigned NbWords = 2 ** `TCDM_ADDR_W;
  localparam int unsigned Timeout = 20;  // Cycles per wait

  logic                     clk_i;
  logic                     rst_ni;
  logic                     clear_i;
  logic                     invert_prio_i;
  stall_cnt_t               low_prio_max_stall_i;
  logic [`TCDM_NB_CHAN-1:0] hi_req_i;
  logic [`TCDM_NB_CHAN-1:0] hi_gnt_o;
  logic [`TCDM_NB_CHAN-1:0] hi_wen_i;
  logic [`TCDM_NB_CHAN-1:0] hi_r_valid_o;
  logic [`TCDM_NB_CHAN-1:0] lo_req_i;
  logic [`TCDM_NB_CHAN-1:0] lo_gnt_o;
  logic [`TCDM_NB_CHAN-1:0] lo_wen_i;
  logic [`TCDM_NB_CHAN-1:0] lo_r_valid_o;
  tcdm_addr_t               hi_add_i    [`TCDM_NB_CHAN];
  tcdm_addr_t               lo_add_i    [`TCDM_NB_CHAN];
  tcdm_be_t                 hi_be_i     [`TCDM_NB_CHAN];
  tcdm_be_t                 lo_be_i     [`TCDM_NB_CHAN];
  tcdm_data_t               hi_data_i   [`TCDM_NB_CHAN];
  tcdm_data_t               lo_data_i   [`TCDM_NB_CHAN];
  tcdm_data_t               hi_r_data_o [`TCDM_NB_CHAN];
  tcdm_data_t               lo_r_data_o [`TCDM_NB_CHAN];
  tcdm_data_t               model [`TCDM_NB_CHAN][NbWords];  // Expected bank contents
  integer                   seed;

  tcdm_subsystem_top dut0 (.*);

  always #50 clk_i = ~clk_i;

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  task automatic stop_failed();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input tcdm_data_t exp, input tcdm_data_t act);
    if (act !== exp)
    begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
    begin
      $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      stop_failed();
    end
  endtask

  // ------------------------------------------------------------
  // Drivers
  // ------------------------------------------------------------

  // Byte-lane merge of a write into the old word
  function automatic tcdm_data_t merge(input tcdm_data_t old, input tcdm_data_t wdata,
                                       input tcdm_be_t be);
    tcdm_data_t res;
    res = old;
    for (int b = 0; b < `TCDM_BE_W; b++)
      if (be[b])
        res[8*b +: 8] = wdata[8*b +: 8];
    return res;
  endfunction

  function automatic logic rvalid_of(input bit lo, input int ch);
    return lo ? lo_r_valid_o[ch] : hi_r_valid_o[ch];
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #10;  // Inputs change well after the edge
  endtask

  task automatic set_req(input bit lo, input int ch, input logic req, input logic wen,
                         input tcdm_addr_t add, input tcdm_be_t be, input tcdm_data_t data);
    if (lo)
    begin
      lo_req_i[ch]  = req;
      lo_wen_i[ch]  = wen;
      lo_add_i[ch]  = add;
      lo_be_i[ch]   = be;
      lo_data_i[ch] = data;
    end
    else
    begin
      hi_req_i[ch]  = req;
      hi_wen_i[ch]  = wen;
      hi_add_i[ch]  = add;
      hi_be_i[ch]   = be;
      hi_data_i[ch] = data;
    end
  endtask

  // Update the model with an accepted write
  task automatic note_write(input bit lo, input int ch);
    if (lo && !lo_wen_i[ch])
      model[ch][lo_add_i[ch]] = merge(model[ch][lo_add_i[ch]], lo_data_i[ch], lo_be_i[ch]);
    else if (!lo && !hi_wen_i[ch])
      model[ch][hi_add_i[ch]] = merge(model[ch][hi_add_i[ch]], hi_data_i[ch], hi_be_i[ch]);
  endtask

  task automatic wait_gnt(input string name, input bit lo, input int ch);
    int n;
    n = 0;
    @(negedge clk_i);
    while ((lo ? lo_gnt_o[ch] : hi_gnt_o[ch]) !== 1'b1)
    begin
      n++;
      if (n > Timeout)
      begin
        $display("%s: no gnt on channel %0d within %0d cycles", name, ch, Timeout);
        stop_failed();
      end
      @(negedge clk_i);
    end
  endtask

  // Wait for accept of a pending request, release it, check the response
  task automatic complete(input string name, input bit lo, input int ch);
    tcdm_addr_t add;
    logic       rd;
    wait_gnt(name, lo, ch);
    check_bit(name, 1'b0, rvalid_of(lo, ch));  // Nothing in flight yet
    next_cycle();
    note_write(lo, ch);
    add = lo ? lo_add_i[ch] : hi_add_i[ch];
    rd  = lo ? lo_wen_i[ch] : hi_wen_i[ch];
    if (lo)
      lo_req_i[ch] = 1'b0;
    else
      hi_req_i[ch] = 1'b0;
    @(negedge clk_i);
    check_bit(name, 1'b1, rvalid_of(lo, ch));   // One cycle after accept
    check_bit(name, 1'b0, rvalid_of(!lo, ch));  // Never on the other side
    if (rd)
      check_data(name, model[ch][add], lo ? lo_r_data_o[ch] : hi_r_data_o[ch]);
  endtask

  task automatic access(input string name, input bit lo, input int ch, input logic wen,
                        input tcdm_addr_t add, input tcdm_be_t be, input tcdm_data_t data);
    next_cycle();
    set_req(lo, ch, 1'b1, wen, add, be, data);
    complete(name, lo, ch);
  endtask

  // Records in lo_won the cycles where the low side wins a contended channel
  task automatic contend(input string name, input int ch, input int cycles, input int clear_at,
                         output int lo_won);
    lo_won = 0;
    for (int c = 0; c < cycles; c++)
    begin
      if (c > 0)
        next_cycle();
      clear_i = (c == clear_at);
      @(negedge clk_i);
      check_bit(name, 1'b1, hi_gnt_o[ch] ^ lo_gnt_o[ch]);  // Exactly one winner
      if (lo_gnt_o[ch])
        lo_won |= 1 << c;
      note_write(lo_gnt_o[ch], ch);
    end
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------

  task automatic single_side_access();
    tcdm_addr_t add;
    for (int ch = 0; ch < `TCDM_NB_CHAN; ch++)
    begin
      for (int k = 0; k < 3; k++)
      begin
        add = tcdm_addr_t'($random(seed));
        access("single_side wr", 1'b1, ch, 1'b0, add, '1, tcdm_data_t'($random(seed)));
        access("single_side be", 1'b1, ch, 1'b0, add, tcdm_be_t'($random(seed)),
               tcdm_data_t'($random(seed)));
        access("single_side rd", 1'b1, ch, 1'b1, add, '0, '0);
      end
    end
  endtask

  task automatic default_priority();
    int lw;
    next_cycle();
    low_prio_max_stall_i = '0;  // Limit off
    set_req(1'b0, 0, 1'b1, 1'b0, 6'd10, '1, tcdm_data_t'($random(seed)));
    set_req(1'b1, 0, 1'b1, 1'b0, 6'd11, '1, tcdm_data_t'($random(seed)));
    contend("default_prio", 0, 12, -1, lw);
    check_count("default_prio lo grants", 0, lw);
    next_cycle();
    hi_req_i[0] = 1'b0;
    complete("default_prio lo late", 1'b1, 0);
  endtask

  task automatic starvation_bound(input string name, input int cycles, input int clear_at,
                                  input int exp_lo);
    int lw;
    next_cycle();
    low_prio_max_stall_i = stall_cnt_t'(3);
    set_req(1'b0, 0, 1'b1, 1'b0, 6'd12, '1, tcdm_data_t'($random(seed)));
    set_req(1'b1, 0, 1'b1, 1'b0, 6'd13, '1, tcdm_data_t'($random(seed)));
    contend(name, 0, cycles, clear_at, lw);
    check_count(name, exp_lo, lw);
    next_cycle();
    hi_req_i[0] = 1'b0;
    lo_req_i[0] = 1'b0;
    access(name, 1'b1, 0, 1'b1, 6'd13, '0, '0);
  endtask

  task automatic priority_swap();
    int lw;
    next_cycle();
    invert_prio_i        = 1'b1;
    low_prio_max_stall_i = '0;
    set_req(1'b0, 1, 1'b1, 1'b0, 6'd40, '1, tcdm_data_t'($random(seed)));
    set_req(1'b1, 1, 1'b1, 1'b0, 6'd41, '1, tcdm_data_t'($random(seed)));
    contend("prio_swap", 1, 8, -1, lw);
    check_count("prio_swap lo grants", 32'hff, lw);  // Low side wins all 8 cycles
    next_cycle();
    lo_req_i[1] = 1'b0;
    complete("prio_swap hi late", 1'b0, 1);  // Write lands only now
    access("prio_swap hi rd", 1'b0, 1, 1'b1, 6'd40, '0, '0);
  endtask

  task automatic independent_channels();
    next_cycle();
    invert_prio_i = 1'b0;
    set_req(1'b0, 0, 1'b1, 1'b0, 6'd33, '1, tcdm_data_t'($random(seed)));
    set_req(1'b1, 1, 1'b1, 1'b0, 6'd34, '1, tcdm_data_t'($random(seed)));
    @(negedge clk_i);
    check_bit("indep_chan hi gnt", 1'b1, hi_gnt_o[0]);
    check_bit("indep_chan lo gnt", 1'b1, lo_gnt_o[1]);
    next_cycle();
    note_write(1'b0, 0);
    note_write(1'b1, 1);
    hi_req_i[0] = 1'b0;
    lo_req_i[1] = 1'b0;
    @(negedge clk_i);
    check_bit("indep_chan hi r_valid", 1'b1, hi_r_valid_o[0]);
    check_bit("indep_chan lo r_valid", 1'b1, lo_r_valid_o[1]);
    check_bit("indep_chan hi idle", 1'b0, hi_r_valid_o[1]);
    check_bit("indep_chan lo idle", 1'b0, lo_r_valid_o[0]);
    access("indep_chan hi rd", 1'b0, 0, 1'b1, 6'd33, '0, '0);
    access("indep_chan lo rd", 1'b1, 1, 1'b1, 6'd34, '0, '0);
  endtask

  initial
  begin
    seed                 = 32'h42f2_3469;
    clk_i                = 1'b0;
    rst_ni               = 1'b0;
    clear_i              = 1'b0;
    invert_prio_i        = 1'b0;
    low_prio_max_stall_i = '0;
    for (int ch = 0; ch < `TCDM_NB_CHAN; ch++)
    begin
      set_req(1'b0, ch, 1'b0, 1'b1, '0, '0, '0);
      set_req(1'b1, ch, 1'b0, 1'b1, '0, '0, '0);
    end
    repeat (8) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;

    single_side_access();
    default_priority();
    starvation_bound("stall_bound", 16, -1, 32'h8888);  // Low wins every 4th cycle
    priority_swap();
    independent_channels();
    starvation_bound("clear", 10, 2, 32'h40);  // Count restarts after the clear

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- project.f
+incdir+verilog
verilog/tcdm_pkg.sv
verilog/tcdm_bus_if.sv
verilog/prio_arbiter.sv
verilog/tcdm_bank.sv
verilog/resp_steer.sv
verilog/tcdm_subsystem_top.sv
testbench/tb_tcdm_subsystem.sv

//--- Bender.yml
package:
  name: tcdm_subsystem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/tcdm_pkg.sv
      - verilog/tcdm_bus_if.sv
      - verilog/prio_arbiter.sv
      - verilog/tcdm_bank.sv
      - verilog/resp_steer.sv
      - verilog/tcdm_subsystem_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_tcdm_subsystem.sv
